// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f vlog.f -o uart_sim
	@out="$$(./obj_dir/uart_sim)"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

// ==== uart_bank.sv ====
`default_nettype none

`include "uart_params.svh"

module uart_bank (
  input  wire                           clock,
  input  wire                           reset,
  input  wire uart_reg_pkg::reg_addr_t  addr,
  input  wire                           wr_en,
  input  wire                           rd_en,
  input  wire uart_reg_pkg::bus_word_t  wr_data,
  output uart_reg_pkg::bus_word_t       rd_data,
  output logic                          tx_push,
  output uart_phy_pkg::uart_byte_t      tx_wdata,
  input  wire                           tx_full,
  input  wire uart_phy_pkg::fifo_cnt_t  tx_count,
  output logic                          rx_pop,
  input  wire                           rx_empty,
  input  wire uart_phy_pkg::fifo_cnt_t  rx_count,
  input  wire uart_phy_pkg::uart_byte_t rx_rdata,
  output logic                          txen,
  output logic                          nstop,
  output logic                          rxen,
  output uart_phy_pkg::baud_div_t       div,
  output logic                          irq
);
  import uart_reg_pkg::*;
  import uart_phy_pkg::*;

  wmark_t     txcnt_q;
  wmark_t     rxcnt_q;
  logic [1:0] ie_q;
  logic [1:0] ip;
  uart_byte_t rx_byte;
  bus_word_t  rd_word;

  // Bytes to a full transmit FIFO are dropped here
  assign tx_push  = wr_en && (addr == ADDR_TXDATA) && !tx_full;
  assign tx_wdata = wr_data[7:0];
  assign rx_pop   = rd_en && (addr == ADDR_RXDATA) && !rx_empty;

  // Watermark pending bits
  assign ip[0] = (tx_count < fifo_cnt_t'(txcnt_q)) && ie_q[0];
  assign ip[1] = (rx_count > fifo_cnt_t'(rxcnt_q)) && ie_q[1];
  assign irq   = |ip;

  assign rx_byte = rx_empty ? '0 : rx_rdata;

  always_comb begin
    case (addr)
      ADDR_TXDATA: rd_word = {tx_full, 31'b0};
      ADDR_RXDATA: rd_word = {rx_empty, 23'b0, rx_byte};
      ADDR_TXCTRL: rd_word = {13'b0, txcnt_q, 14'b0, nstop, txen};
      ADDR_RXCTRL: rd_word = {13'b0, rxcnt_q, 15'b0, rxen};
      ADDR_IE:     rd_word = {30'b0, ie_q};
      ADDR_IP:     rd_word = {30'b0, ip};
      ADDR_DIV:    rd_word = {16'b0, div};
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      txen    <= 1'b0;
      nstop   <= 1'b0;
      txcnt_q <= '0;
      rxen    <= 1'b0;
      rxcnt_q <= '0;
      ie_q    <= '0;
      div     <= baud_div_t'(`UART_DIV_INIT);
    end else if (wr_en) begin
      case (addr)
        ADDR_TXCTRL: begin
          txen    <= wr_data[0];
          nstop   <= wr_data[1];
          txcnt_q <= wr_data[18:16];
        end
        ADDR_RXCTRL: begin
          rxen    <= wr_data[0];
          rxcnt_q <= wr_data[18:16];
        end
        ADDR_IE:  ie_q <= wr_data[1:0];
        ADDR_DIV: div  <= wr_data[15:0];
        default: ;
      endcase
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clock, posedge reset) begin
    if (reset) rd_data <= '0;
    else if (rd_en) rd_data <= rd_word;
  end

endmodule

`default_nettype wire

// ==== uart_checker.sv ====
`default_nettype none

`include "uart_params.svh"

module uart_checker (
  input wire                          clock,
  input wire                          reset,
  input wire                          tx_full,
  input wire                          tx_empty,
  input wire uart_phy_pkg::fifo_cnt_t tx_count,
  input wire                          rx_full,
  input wire                          rx_empty,
  input wire uart_phy_pkg::fifo_cnt_t rx_count,
  input wire                          txd
);
  import uart_phy_pkg::*;

  localparam fifo_cnt_t DEPTH_CNT = fifo_cnt_t'(`UART_FIFO_DEPTH);

  tx_count_bound: assert property (@(posedge clock) disable iff (reset)
    tx_count <= DEPTH_CNT)
    else $error("transmit FIFO count %0d above depth", tx_count);

  rx_count_bound: assert property (@(posedge clock) disable iff (reset)
    rx_count <= DEPTH_CNT)
    else $error("receive FIFO count %0d above depth", rx_count);

  tx_flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(tx_full && tx_empty))
    else $error("transmit FIFO full and empty together");

  rx_flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(rx_full && rx_empty))
    else $error("receive FIFO full and empty together");

  // Line must idle high during reset
  txd_high_in_reset: assert property (@(posedge clock) reset |-> txd)
    else $error("txd low while reset is high");

endmodule

bind uart_top uart_checker checker_i (
  .clock(clock), .reset(reset),
  .tx_full(tx_full), .tx_empty(tx_empty), .tx_count(tx_count),
  .rx_full(rx_full), .rx_empty(rx_empty), .rx_count(rx_count),
  .txd(txd)
);

`default_nettype wire

// ==== uart_clock_gen.sv ====
`default_nettype none

module uart_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Release away from the rising edge
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== uart_fifo.sv ====
`default_nettype none

`include "uart_params.svh"

module uart_fifo #(
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        push,
  input  wire uart_phy_pkg::uart_byte_t wdata,
  input  wire                        pop,
  output uart_phy_pkg::uart_byte_t   rdata,
  output logic                       full,
  output logic                       empty,
  output uart_phy_pkg::fifo_cnt_t    count
);
  import uart_phy_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  uart_byte_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign full    = (count == fifo_cnt_t'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head is visible before the pop
  assign rdata = mem_q[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) mem_q[wr_ptr] <= wdata;
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_input.txt ====
// test op addr data expect (hex); op 0 write, 1 read, 2 poll rx, 3 random tx (data=count,
// expect=kept), 4 poll rx against random bytes, 5 idle cycles, 6 check irq, 7 poll register
1 1 6 0 55
1 1 2 0 0
1 1 3 0 0
1 1 4 0 0
1 1 5 0 0
1 1 1 0 80000000
2 0 2 ffffffff 0
2 1 2 0 00070003
2 0 3 ffffffff 0
2 1 3 0 00070001
2 0 4 ffffffff 0
2 1 4 0 3
2 0 6 12345678 0
2 1 6 0 5678
3 0 6 3 0
3 0 3 1 0
3 0 2 1 0
3 0 0 a5 0
3 2 1 0 a5
3 0 0 3c 0
3 2 1 0 3c
3 3 0 6 6
3 4 1 6 0
3 1 1 0 80000000
4 0 2 0 0
4 3 0 8 8
4 1 0 0 80000000
4 3 0 1 0
4 0 2 1 0
4 4 1 8 0
4 5 0 64 0
4 1 1 0 80000000
5 0 2 00020001 0
5 0 4 1 0
5 1 5 0 1
5 6 0 0 1
5 0 3 1 0
5 0 4 2 0
5 1 5 0 0
5 6 0 0 0
5 0 0 5a 0
5 7 5 0 2
5 6 0 0 1
5 2 1 0 5a
5 1 5 0 0
5 6 0 0 0
6 0 2 3 0
6 3 0 4 4
6 4 1 4 0
6 1 1 0 80000000

// ==== uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// FIFO geometry
`define UART_FIFO_DEPTH 8
`define UART_CNT_W 4

// Character width on the line
`define UART_BYTE_W 8

// System clock and default line rate
`define UART_CLOCK_HZ 10000000
`define UART_BAUD_DEFAULT 115200

// Divisor so that one bit lasts divisor plus one clocks
`define UART_DIV_INIT (`UART_CLOCK_HZ / `UART_BAUD_DEFAULT - 1)

`endif

// ==== uart_phy_pkg.sv ====
`default_nettype none

`include "uart_params.svh"

package uart_phy_pkg;

  typedef logic [`UART_BYTE_W-1:0] uart_byte_t;
  typedef logic [15:0] baud_div_t;
  typedef logic [`UART_CNT_W-1:0] fifo_cnt_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// ==== uart_reg_pkg.sv ====
`default_nettype none

package uart_reg_pkg;

  // Word addresses on the register bus, 7 is reserved
  typedef enum logic [2:0] {
    ADDR_TXDATA = 3'd0,
    ADDR_RXDATA = 3'd1,
    ADDR_TXCTRL = 3'd2,
    ADDR_RXCTRL = 3'd3,
    ADDR_IE     = 3'd4,
    ADDR_IP     = 3'd5,
    ADDR_DIV    = 3'd6
  } reg_addr_t;

  typedef logic [31:0] bus_word_t;

  // FIFO level thresholds for txcnt and rxcnt
  typedef logic [2:0] wmark_t;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

module uart_rx (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          rxen,
  input  wire uart_phy_pkg::baud_div_t div,
  input  wire                          rxd,
  output logic                         push,
  output uart_phy_pkg::uart_byte_t     data
);
  import uart_phy_pkg::*;

  rx_state_t  state;
  baud_div_t  baud_cnt;
  baud_div_t  half_div;
  logic [2:0] bit_idx;
  uart_byte_t shift_q;
  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic       bit_done;
  logic       half_done;

  assign half_div  = div >> 1;
  assign bit_done  = (baud_cnt == div);
  assign half_done = (baud_cnt == half_div);
  assign data      = shift_q;

  // Two-stage synchronizer plus edge history, line idles high
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clock) begin
    if (state == RX_DATA && bit_done) shift_q <= {rxd_sync, shift_q[7:1]};
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (rxen && rxd_prev && !rxd_sync) state <= RX_START;
        end
        RX_START: begin
          baud_cnt <= half_done ? '0 : baud_cnt + 1'b1;
          if (half_done) begin
            bit_idx <= '0;
            // Glitch filter, start bit must still be low
            state   <= rxd_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
          if (bit_done) begin
            if (bit_idx == 3'd7) state <= RX_STOP;
            else bit_idx <= bit_idx + 1'b1;
          end
        end
        RX_STOP: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
          if (bit_done) begin
            push  <= rxd_sync;
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_tb.sv ====
`default_nettype none

module uart_tb;
  import uart_reg_pkg::*;

  localparam int MAX_OPS = 64;
  localparam int TEST_DIV = 3;
  localparam int POLL_LIMIT = 2000;
  localparam int PERIOD = 100;

  logic      clock;
  logic      reset;
  reg_addr_t addr;
  logic      wr_en;
  logic      rd_en;
  bus_word_t wr_data;
  bus_word_t rd_data;
  logic      txd;
  logic      irq;

  bus_word_t   prog [MAX_OPS*5];
  logic [7:0]  expect_q [$];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          test_errors;
  longint      limit;
  logic        limit_ready;

  uart_clock_gen clock_gen_i (.clock(clock), .reset(reset));

  // Serial loopback
  uart_top dut_i (
    .clock(clock), .reset(reset), .addr(addr), .wr_en(wr_en), .rd_en(rd_en),
    .wr_data(wr_data), .rd_data(rd_data), .txd(txd), .rxd(txd), .irq(irq)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic note_failure(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endtask

  task automatic check_word(input string what, input bus_word_t got, input bus_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic bus_write(input reg_addr_t a, input bus_word_t d);
    @(negedge clock);
    addr    = a;
    wr_data = d;
    wr_en   = 1'b1;
    @(negedge clock);
    wr_en   = 1'b0;
  endtask

  // Read data is registered and sampled one cycle after rd_en
  task automatic bus_read(input reg_addr_t a, output bus_word_t d);
    @(negedge clock);
    addr  = a;
    rd_en = 1'b1;
    @(negedge clock);
    rd_en = 1'b0;
    d     = rd_data;
  endtask

  task automatic poll_rx(output bus_word_t word, output bit ok);
    int n;
    ok   = 1'b0;
    word = '0;
    for (n = 0; n < POLL_LIMIT && !ok; n++) begin
      bus_read(ADDR_RXDATA, word);
      if (!word[31]) ok = 1'b1;
    end
  endtask

  task automatic poll_reg(input reg_addr_t a, input bus_word_t exp, output bit ok);
    int n;
    bus_word_t word;
    ok = 1'b0;
    for (n = 0; n < POLL_LIMIT && !ok; n++) begin
      bus_read(a, word);
      if (word === exp) ok = 1'b1;
    end
  endtask

  task automatic report_test(input int t, input int n);
    $display("test %0d finished with %0d errors", t, n);
  endtask

  initial begin
    wait (limit_ready);
    #(limit);
    $display("Watchdog expired at %0t, the run did not finish in time", $time);
    $display("Errors found");
    $finish;
  end

  initial begin
    int idx;
    int n;
    int cur_test;
    longint bytes;
    longint idle;
    bus_word_t op;
    bus_word_t a;
    bus_word_t d;
    bus_word_t e;
    bus_word_t word;
    bit ok;

    addr        = ADDR_TXDATA;
    wr_en       = 1'b0;
    rd_en       = 1'b0;
    wr_data     = '0;
    lcg_state   = 32'h48a9;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    bytes       = 0;
    idle        = 0;
    limit_ready = 1'b0;
    for (idx = 0; idx < MAX_OPS * 5; idx++) prog[idx] = '0;
    $readmemh("uart_input.txt", prog);

    // Two frames of 12 bit times per byte plus bus time and margin
    for (idx = 0; idx < MAX_OPS && prog[idx*5] != 0; idx++) begin
      if (prog[idx*5+1] == 0 && prog[idx*5+2] == 0) bytes++;
      if (prog[idx*5+1] == 3) bytes += prog[idx*5+3];
      if (prog[idx*5+1] == 5) idle += prog[idx*5+3];
    end
    limit = (bytes * 2 * 12 * (TEST_DIV + 1) + idle + idx * 50 + 1000) * PERIOD;
    limit_ready = 1'b1;

    @(negedge reset);
    cur_test = int'(prog[0]);
    for (idx = 0; idx < MAX_OPS && prog[idx*5] != 0; idx++) begin
      op = prog[idx*5+1];
      a  = prog[idx*5+2];
      d  = prog[idx*5+3];
      e  = prog[idx*5+4];
      if (int'(prog[idx*5]) != cur_test) begin
        report_test(cur_test, test_errors);
        cur_test    = int'(prog[idx*5]);
        test_errors = 0;
      end
      case (op)
        0: bus_write(reg_addr_t'(a[2:0]), d);
        1: begin
          bus_read(reg_addr_t'(a[2:0]), word);
          check_word($sformatf("register %0d", a), word, e);
        end
        2: begin
          poll_rx(word, ok);
          if (!ok) note_failure($sformatf("test %0d: no byte arrived", cur_test));
          else check_word("received byte", word, e);
        end
        3: for (n = 0; n < int'(d); n++) begin
          lcg_state = lcg_next(lcg_state);
          bus_write(ADDR_TXDATA, {24'b0, lcg_state[23:16]});
          // Bytes past a full FIFO are lost
          if (n < int'(e)) expect_q.push_back(lcg_state[23:16]);
        end
        4: for (n = 0; n < int'(d); n++) begin
          poll_rx(word, ok);
          if (!ok) note_failure($sformatf("test %0d: random byte %0d never arrived", cur_test, n));
          else if (expect_q.size() == 0)
            note_failure($sformatf("test %0d: byte arrived that was never sent", cur_test));
          else check_word("received byte", word, {24'b0, expect_q.pop_front()});
        end
        5: repeat (int'(d)) @(negedge clock);
        6: begin
          checks++;
          if (irq !== e[0]) begin
            errors++;
            test_errors++;
            $display("MISMATCH at %0t: irq is %b, expected %b", $time, irq, e[0]);
          end
        end
        7: begin
          poll_reg(reg_addr_t'(a[2:0]), e, ok);
          if (!ok) note_failure($sformatf("test %0d: register %0d never read %h", cur_test, a, e));
        end
        default: note_failure($sformatf("test %0d: unknown operation %0d", cur_test, op));
      endcase
    end
    report_test(cur_test, test_errors);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_top.sv ====
`default_nettype none

module uart_top (
  input  wire                          clock,
  input  wire                          reset,
  input  wire uart_reg_pkg::reg_addr_t addr,
  input  wire                          wr_en,
  input  wire                          rd_en,
  input  wire uart_reg_pkg::bus_word_t wr_data,
  output uart_reg_pkg::bus_word_t      rd_data,
  output logic                         txd,
  input  wire                          rxd,
  output logic                         irq
);
  import uart_phy_pkg::*;

  logic       tx_push;
  logic       tx_pop;
  logic       tx_full;
  logic       tx_empty;
  uart_byte_t tx_wdata;
  uart_byte_t tx_rdata;
  fifo_cnt_t  tx_count;
  logic       rx_push;
  logic       rx_pop;
  logic       rx_full;
  logic       rx_empty;
  uart_byte_t rx_wdata;
  uart_byte_t rx_rdata;
  fifo_cnt_t  rx_count;
  logic       txen;
  logic       nstop;
  logic       rxen;
  baud_div_t  div;

  uart_bank bank_i (
    .clock(clock), .reset(reset), .addr(addr), .wr_en(wr_en), .rd_en(rd_en),
    .wr_data(wr_data), .rd_data(rd_data),
    .tx_push(tx_push), .tx_wdata(tx_wdata), .tx_full(tx_full), .tx_count(tx_count),
    .rx_pop(rx_pop), .rx_empty(rx_empty), .rx_count(rx_count), .rx_rdata(rx_rdata),
    .txen(txen), .nstop(nstop), .rxen(rxen), .div(div), .irq(irq)
  );

  // rx_full is left for the checker, overflow simply drops bytes
  uart_fifo tx_fifo_i (
    .clock(clock), .reset(reset), .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
    .rdata(tx_rdata), .full(tx_full), .empty(tx_empty), .count(tx_count)
  );

  uart_fifo rx_fifo_i (
    .clock(clock), .reset(reset), .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
    .rdata(rx_rdata), .full(rx_full), .empty(rx_empty), .count(rx_count)
  );

  uart_tx tx_i (
    .clock(clock), .reset(reset), .txen(txen), .nstop(nstop), .div(div),
    .fifo_empty(tx_empty), .fifo_data(tx_rdata), .fifo_pop(tx_pop), .txd(txd)
  );

  uart_rx rx_i (
    .clock(clock), .reset(reset), .rxen(rxen), .div(div), .rxd(rxd),
    .push(rx_push), .data(rx_wdata)
  );

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           txen,
  input  wire                           nstop,
  input  wire uart_phy_pkg::baud_div_t  div,
  input  wire                           fifo_empty,
  input  wire uart_phy_pkg::uart_byte_t fifo_data,
  output logic                          fifo_pop,
  output logic                          txd
);
  import uart_phy_pkg::*;

  tx_state_t  state;
  baud_div_t  baud_cnt;
  logic [2:0] bit_idx;
  uart_byte_t shift_q;
  logic       bit_done;

  assign bit_done = (baud_cnt == div);
  assign fifo_pop = (state == TX_IDLE) && txen && !fifo_empty;

  always_ff @(posedge clock) begin
    if (fifo_pop) shift_q <= fifo_data;
    else if (state == TX_DATA && bit_done) shift_q <= shift_q >> 1;
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      txd      <= 1'b1;
    end else begin
      baud_cnt <= (state == TX_IDLE || bit_done) ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          txd <= 1'b1;
          if (fifo_pop) begin
            txd   <= 1'b0;
            state <= TX_START;
          end
        end
        TX_START: if (bit_done) begin
          txd     <= shift_q[0];
          bit_idx <= '0;
          state   <= TX_DATA;
        end
        TX_DATA: if (bit_done) begin
          if (bit_idx == 3'd7) begin
            txd     <= 1'b1;
            bit_idx <= '0;
            state   <= TX_STOP;
          end else begin
            // Next bit, the shift register moves at this same edge
            txd     <= shift_q[1];
            bit_idx <= bit_idx + 1'b1;
          end
        end
        TX_STOP: if (bit_done) begin
          if (nstop && bit_idx == 3'd0) bit_idx <= 3'd1;
          else state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
uart_reg_pkg.sv
uart_phy_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_bank.sv
uart_top.sv
uart_clock_gen.sv
uart_checker.sv
uart_tb.sv
